//--- rtl/cpuPkg.sv
package cpuPkg;

    parameter int dataWidth  = 8;
    parameter int instrWidth = 16;

    typedef logic [dataWidth-1:0] byteT;
    typedef logic [1:0]           regIdxT;   // R1..R4 as 0..3

    typedef enum logic [1:0] {
        regClear = 2'b00,
        regLoad  = 2'b01,
        regDec   = 2'b10,
        regInc   = 2'b11
    } regFunT;

    typedef enum logic [3:0] {
        passA, passB, notA, add, sub, andOp, orOp, lsl, lsr
    } aluOpT;

    typedef enum logic [3:0] {
        opAnd = 4'd0,  opOr  = 4'd1,  opNot = 4'd2,  opAdd = 4'd3,
        opSub = 4'd4,  opLsr = 4'd5,  opLsl = 4'd6,  opInc = 4'd7,
        opDec = 4'd8,  opBra = 4'd9,  opBne = 4'd10, opMov = 4'd11,
        opLd  = 4'd12, opSt  = 4'd13, opNopE = 4'd14, opNopF = 4'd15
    } opcodeT;

    typedef struct packed {
        opcodeT      opcode;
        logic        spare11;
        logic        mode;     // 1 selects AR dest or direct LD
        regIdxT      dst;
        logic [1:0]  spare7;
        regIdxT      srcA;
        logic [1:0]  spare3;
        regIdxT      srcB;
    } instrFieldsT;

    typedef union packed {
        instrFieldsT fld;
        struct packed {
            byteT hi;
            byteT lo;  // immediate or branch target
        } half;
    } instrT;

    typedef enum logic [1:0] {fetchLow, fetchHigh, execute} cpuStateT;

    typedef struct packed {
        logic zero;
        logic carry;
        logic negative;
        logic overflow;
    } flagsT;

    typedef enum logic [1:0] {rfAlu, rfMem, rfIrLow} rfInSrcT;
    typedef enum logic       {arfAlu, arfIrLow} arfInSrcT;
    typedef enum logic       {addrPc, addrAr} addrSrcT;

    typedef struct packed {
        logic [3:0] rfLoad;    // one-hot, bit 0 is R1
        regFunT     rfFun;
        regIdxT     rfSelA;
        regIdxT     rfSelB;
        aluOpT      aluOp;
        logic       flagsWe;
        logic       pcEn;
        logic       arEn;
        regFunT     arfFun;
        addrSrcT    addrSel;
        logic       irEn;
        logic       irHigh;
        logic       memWr;
        rfInSrcT    rfInSel;
        arfInSrcT   arfInSel;
    } ctrlT;

    typedef struct packed {
        logic en;
        byteT addr;
        byteT data;
    } loadReqT;

    typedef struct packed {
        byteT [3:0] r;
        byteT       pc;
        byteT       ar;
        flagsT      flags;
    } archStateT;

endpackage

//--- rtl/counterReg.sv
`timescale 1ns/1ps

module counterReg #(
    parameter int width = 8
) (
    input  logic             CLK,
    input  logic             rstN,
    input  logic             en,
    input  cpuPkg::regFunT   fun,
    input  logic [width-1:0] d,
    output logic [width-1:0] q
);

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            q <= '0;
        end else if (en) begin
            case (fun)
                cpuPkg::regClear: q <= '0;
                cpuPkg::regLoad:  q <= d;
                cpuPkg::regDec:   q <= q - 1'b1;  // wraps at zero
                default:          q <= q + 1'b1;
            endcase
        end
    end

endmodule

//--- rtl/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic                 CLK,
    input  logic                 rstN,
    input  logic [3:0]           load,
    input  cpuPkg::regFunT       fun,
    input  cpuPkg::byteT         d,
    input  cpuPkg::regIdxT       selA,
    input  cpuPkg::regIdxT       selB,
    output cpuPkg::byteT         a,
    output cpuPkg::byteT         b,
    output cpuPkg::byteT [3:0]   regs
);

    // R1..R4, all sharing the same input and function
    for (genvar i = 0; i < 4; i++) begin : gReg
        counterReg #(
            .width(cpuPkg::dataWidth)
        ) uReg (
            .CLK  (CLK),
            .rstN (rstN),
            .en   (load[i]),
            .fun  (fun),
            .d    (d),
            .q    (regs[i])
        );
    end

    // two independent read ports for the ALU
    assign a = regs[selA];
    assign b = regs[selB];

endmodule

//--- rtl/addressRegFile.sv
`timescale 1ns/1ps

module addressRegFile (
    input  logic              CLK,
    input  logic              rstN,
    input  logic              pcEn,
    input  logic              arEn,
    input  cpuPkg::regFunT    fun,
    input  cpuPkg::byteT      d,
    input  cpuPkg::addrSrcT   addrSel,
    output cpuPkg::byteT      address,
    output cpuPkg::byteT      pc,
    output cpuPkg::byteT      ar
);

    counterReg #(.width(cpuPkg::dataWidth)) uPc (
        .CLK(CLK), .rstN(rstN), .en(pcEn), .fun(fun), .d(d), .q(pc)
    );

    counterReg #(.width(cpuPkg::dataWidth)) uAr (
        .CLK(CLK), .rstN(rstN), .en(arEn), .fun(fun), .d(d), .q(ar)
    );

    assign address = (addrSel == cpuPkg::addrAr) ? ar : pc;  // memory address

endmodule

//--- rtl/instrRegister.sv
`timescale 1ns/1ps

module instrRegister (
    input  logic           CLK,
    input  logic           rstN,
    input  logic           en,
    input  logic           high,
    input  cpuPkg::byteT   d,
    output cpuPkg::instrT  ir
);

    logic [cpuPkg::instrWidth-1:0] irQ;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            irQ <= '0;
        end else if (en) begin
            if (high)
                irQ[cpuPkg::instrWidth-1:cpuPkg::dataWidth] <= d;
            else
                irQ[cpuPkg::dataWidth-1:0] <= d;  // other half kept
        end
    end

    assign ir = irQ;

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic            CLK,
    input  logic            rstN,
    input  cpuPkg::byteT    a,
    input  cpuPkg::byteT    b,
    input  cpuPkg::aluOpT   op,
    input  logic            flagsWe,
    output cpuPkg::byteT    result,
    output cpuPkg::flagsT   flags
);

    logic                     isSub;
    cpuPkg::byteT             bOp;
    logic [cpuPkg::dataWidth:0] sum9;
    logic                     ovf;
    cpuPkg::flagsT            nextFlags;

    // shared adder, SUB is a + ~b + 1
    assign isSub = (op == cpuPkg::sub);
    assign bOp   = isSub ? ~b : b;
    assign sum9  = {1'b0, a} + {1'b0, bOp} + {{cpuPkg::dataWidth{1'b0}}, isSub};
    assign ovf   = (a[cpuPkg::dataWidth-1] == bOp[cpuPkg::dataWidth-1])
                && (sum9[cpuPkg::dataWidth-1] != a[cpuPkg::dataWidth-1]);

    always_comb begin
        case (op)
            cpuPkg::passA: result = a;
            cpuPkg::passB: result = b;
            cpuPkg::notA:  result = ~a;
            cpuPkg::add,
            cpuPkg::sub:   result = sum9[cpuPkg::dataWidth-1:0];
            cpuPkg::andOp: result = a & b;
            cpuPkg::orOp:  result = a | b;
            cpuPkg::lsl:   result = {a[cpuPkg::dataWidth-2:0], 1'b0};
            cpuPkg::lsr:   result = {1'b0, a[cpuPkg::dataWidth-1:1]};
            default:       result = a;
        endcase
    end

    always_comb begin
        nextFlags          = flags;  // C and O hold by default
        nextFlags.zero     = (result == '0);
        nextFlags.negative = result[cpuPkg::dataWidth-1];
        case (op)
            cpuPkg::add,
            cpuPkg::sub: begin
                nextFlags.carry    = sum9[cpuPkg::dataWidth];
                nextFlags.overflow = ovf;
            end
            cpuPkg::lsl: nextFlags.carry = a[cpuPkg::dataWidth-1];
            cpuPkg::lsr: nextFlags.carry = a[0];
            default: ;
        endcase
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN)
            flags <= '0;
        else if (flagsWe)
            flags <= nextFlags;
    end

endmodule

//--- rtl/dataMemory.sv
`timescale 1ns/1ps

module dataMemory (
    input  logic             CLK,
    input  cpuPkg::byteT     address,
    input  cpuPkg::byteT     wrData,
    input  logic             wr,
    input  cpuPkg::loadReqT  load,
    output cpuPkg::byteT     rdData
);

    cpuPkg::byteT mem [2**cpuPkg::dataWidth];

    assign rdData = mem[address];  // async read

    always_ff @(posedge CLK) begin
        if (load.en)
            mem[load.addr] <= load.data;  // program load wins
        else if (wr)
            mem[address] <= wrData;
    end

endmodule

//--- rtl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  logic            CLK,
    input  logic            rstN,
    input  logic            run,
    input  cpuPkg::instrT   ir,
    input  cpuPkg::flagsT   flags,
    output cpuPkg::ctrlT    ctrl,
    output logic            instrDone
);

    cpuPkg::cpuStateT state;
    cpuPkg::cpuStateT stateNext;

    always_comb begin
        case (state)
            cpuPkg::fetchLow:  stateNext = run ? cpuPkg::fetchHigh : cpuPkg::fetchLow;
            cpuPkg::fetchHigh: stateNext = cpuPkg::execute;
            default:           stateNext = cpuPkg::fetchLow;
        endcase
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN)
            state <= cpuPkg::fetchLow;
        else
            state <= stateNext;
    end

    assign instrDone = (state == cpuPkg::execute);

    always_comb begin
        logic [3:0] dstHot;
        logic       aluWrite;
        dstHot   = 4'b0001 << ir.fld.dst;
        aluWrite = 1'b0;
        ctrl          = '0;
        ctrl.rfFun    = cpuPkg::regLoad;
        ctrl.arfFun   = cpuPkg::regLoad;
        ctrl.aluOp    = cpuPkg::passA;
        ctrl.addrSel  = cpuPkg::addrPc;
        ctrl.rfInSel  = cpuPkg::rfAlu;
        ctrl.arfInSel = cpuPkg::arfAlu;
        case (state)
            cpuPkg::fetchLow: begin
                if (run) begin
                    ctrl.irEn   = 1'b1;
                    ctrl.pcEn   = 1'b1;
                    ctrl.arfFun = cpuPkg::regInc;
                end
            end
            cpuPkg::fetchHigh: begin
                ctrl.irEn   = 1'b1;
                ctrl.irHigh = 1'b1;
                ctrl.pcEn   = 1'b1;
                ctrl.arfFun = cpuPkg::regInc;
            end
            default: begin
                ctrl.rfSelA = ir.fld.srcA;
                ctrl.rfSelB = ir.fld.srcB;
                case (ir.fld.opcode)
                    cpuPkg::opAnd: begin aluWrite = 1'b1; ctrl.aluOp = cpuPkg::andOp; end
                    cpuPkg::opOr:  begin aluWrite = 1'b1; ctrl.aluOp = cpuPkg::orOp;  end
                    cpuPkg::opNot: begin aluWrite = 1'b1; ctrl.aluOp = cpuPkg::notA;  end
                    cpuPkg::opAdd: begin aluWrite = 1'b1; ctrl.aluOp = cpuPkg::add;   end
                    cpuPkg::opSub: begin aluWrite = 1'b1; ctrl.aluOp = cpuPkg::sub;   end
                    cpuPkg::opLsr: begin aluWrite = 1'b1; ctrl.aluOp = cpuPkg::lsr;   end
                    cpuPkg::opLsl: begin aluWrite = 1'b1; ctrl.aluOp = cpuPkg::lsl;   end
                    cpuPkg::opMov: begin aluWrite = 1'b1; ctrl.aluOp = cpuPkg::passA; end
                    cpuPkg::opInc, cpuPkg::opDec: begin
                        ctrl.rfLoad = dstHot;  // count in place
                        ctrl.rfFun  = (ir.fld.opcode == cpuPkg::opInc) ?
                                      cpuPkg::regInc : cpuPkg::regDec;
                    end
                    cpuPkg::opBra, cpuPkg::opBne: begin
                        ctrl.pcEn     = (ir.fld.opcode == cpuPkg::opBra) || !flags.zero;
                        ctrl.arfInSel = cpuPkg::arfIrLow;
                    end
                    cpuPkg::opLd: begin
                        ctrl.rfLoad = dstHot;
                        if (ir.fld.mode) begin
                            ctrl.addrSel = cpuPkg::addrAr;  // direct, M[AR]
                            ctrl.rfInSel = cpuPkg::rfMem;
                        end else begin
                            ctrl.rfInSel = cpuPkg::rfIrLow;
                        end
                    end
                    cpuPkg::opSt: begin
                        ctrl.rfSelB  = ir.fld.dst;
                        ctrl.aluOp   = cpuPkg::passB;
                        ctrl.addrSel = cpuPkg::addrAr;
                        ctrl.memWr   = 1'b1;
                    end
                    default: ;  // 14 and 15 do nothing
                endcase
                if (aluWrite) begin
                    ctrl.flagsWe = 1'b1;
                    if (ir.fld.mode)
                        ctrl.arEn = 1'b1;
                    else
                        ctrl.rfLoad = dstHot;
                end
            end
        endcase
    end

endmodule

//--- rtl/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
    input  logic               CLK,
    input  logic               rstN,
    input  logic               run,
    input  cpuPkg::loadReqT    load,
    output cpuPkg::archStateT  state,
    output cpuPkg::instrT      ir,
    output logic               instrDone
);

    cpuPkg::ctrlT        ctrl;
    cpuPkg::flagsT       flags;
    cpuPkg::byteT        rfA;
    cpuPkg::byteT        rfB;
    cpuPkg::byteT [3:0]  regs;
    cpuPkg::byteT        aluResult;
    cpuPkg::byteT        memData;
    cpuPkg::byteT        address;
    cpuPkg::byteT        pc;
    cpuPkg::byteT        ar;
    cpuPkg::byteT        rfIn;
    cpuPkg::byteT        arfIn;

    always_comb begin
        case (ctrl.rfInSel)
            cpuPkg::rfMem:   rfIn = memData;
            cpuPkg::rfIrLow: rfIn = ir.half.lo;
            default:         rfIn = aluResult;
        endcase
    end

    assign arfIn = (ctrl.arfInSel == cpuPkg::arfIrLow) ? ir.half.lo : aluResult;

    registerFile uRf (
        .CLK(CLK), .rstN(rstN), .load(ctrl.rfLoad), .fun(ctrl.rfFun), .d(rfIn),
        .selA(ctrl.rfSelA), .selB(ctrl.rfSelB), .a(rfA), .b(rfB), .regs(regs)
    );

    addressRegFile uArf (
        .CLK(CLK), .rstN(rstN), .pcEn(ctrl.pcEn), .arEn(ctrl.arEn), .fun(ctrl.arfFun),
        .d(arfIn), .addrSel(ctrl.addrSel), .address(address), .pc(pc), .ar(ar)
    );

    instrRegister uIr (
        .CLK(CLK), .rstN(rstN), .en(ctrl.irEn), .high(ctrl.irHigh), .d(memData), .ir(ir)
    );

    alu uAlu (
        .CLK(CLK), .rstN(rstN), .a(rfA), .b(rfB), .op(ctrl.aluOp),
        .flagsWe(ctrl.flagsWe), .result(aluResult), .flags(flags)
    );

    dataMemory uMem (
        .CLK(CLK), .address(address), .wrData(aluResult), .wr(ctrl.memWr),
        .load(load), .rdData(memData)
    );

    controlUnit uCtrl (
        .CLK(CLK), .rstN(rstN), .run(run), .ir(ir), .flags(flags),
        .ctrl(ctrl), .instrDone(instrDone)
    );

    assign state.r     = regs;
    assign state.pc    = pc;
    assign state.ar    = ar;
    assign state.flags = flags;

endmodule

//--- dv/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

    localparam int maxCmds = 256;

    logic               CLK;
    logic               rstN;
    logic               run;
    cpuPkg::loadReqT    load;
    cpuPkg::archStateT  state;
    cpuPkg::instrT      ir;
    logic               instrDone;

    logic [31:0] cmds [maxCmds];
    logic [7:0]  shadow [256];  // bytes placed through the load port
    int          cycles = 0;
    int          limit = 0;
    int          testId = 0;
    int          runNum = 0;

    cpuTop DUT (
        .CLK(CLK), .rstN(rstN), .run(run), .load(load),
        .state(state), .ir(ir), .instrDone(instrDone)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    task automatic applyReset();
        rstN = 1'b0;
        run  = 1'b0;
        load = '0;
        repeat (16) @(negedge CLK);
        rstN = 1'b1;
        @(negedge CLK);
    endtask

    task automatic loadByte(input logic [7:0] addr, input logic [7:0] data);
        load.en      = 1'b1;
        load.addr    = addr;
        load.data    = data;
        shadow[addr] = data;
        @(negedge CLK);
        load.en = 1'b0;
    endtask

    task automatic checkIr(input logic [7:0] addr);
        cpuPkg::instrT expected;
        string         name;
        expected = {shadow[addr + 8'd1], shadow[addr]};  // low byte sits first in memory
        name     = $sformatf("run%0d_IR", runNum);
        assert (ir === expected) else begin
            $display("ERROR %s: expected %h, actual %h", name, expected, ir);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic runInstrs(input int count);
        int         done;
        logic [7:0] fetchAddr;
        done      = 0;
        fetchAddr = state.pc;  // first fetch of this run
        runNum++;
        run       = 1'b1;
        while (done < count) begin
            @(negedge CLK);
            if (instrDone) begin
                checkIr(fetchAddr);
                done++;
                if (done < count) begin
                    @(negedge CLK);
                    fetchAddr = state.pc;  // back in fetchLow
                end
            end
        end
        run = 1'b0;  // still inside the last execute cycle
        @(negedge CLK);
    endtask

    function automatic string regName(input int idx);
        case (idx)
            4: return "PC";
            5: return "AR";
            6: return "FLAGS";
            7: return "DONE";
            default: return $sformatf("R%0d", idx + 1);
        endcase
    endfunction

    task automatic checkValue(input int idx, input logic [7:0] expected);
        logic [7:0] actual;
        string      name;
        case (idx)
            4: actual = state.pc;
            5: actual = state.ar;
            6: actual = {4'b0, state.flags};  // Z C N O
            7: actual = {7'b0, instrDone};
            default: actual = state.r[idx[1:0]];
        endcase
        name = $sformatf("test%0d_%s", testId, regName(idx));
        assert (actual === expected) else begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    initial begin
        int          loads;
        int          runs;
        int          resets;
        int          i;
        logic [31:0] cmd;
        rstN   = 1'b1;
        run    = 1'b0;
        load   = '0;
        loads  = 0;
        runs   = 0;
        resets = 0;
        $readmemh("dv/programInput.mem", cmds);
        i = 0;
        while (i < maxCmds && cmds[i][31:24] != 8'h0f) begin
            case (cmds[i][31:24])
                8'h01: loads++;
                8'h02: runs += int'(cmds[i][15:0]);
                8'h04: resets++;
                default: ;
            endcase
            i++;
        end
        limit = 3 * runs + loads + 20 * (resets + 1) + 100;  // first reset counted too

        @(negedge CLK);
        applyReset();
        for (i = 0; i < maxCmds; i++) begin
            cmd = cmds[i];
            if (cmd[31:24] == 8'h0f)
                break;
            case (cmd[31:24])
                8'h01: loadByte(cmd[15:8], cmd[7:0]);
                8'h02: runInstrs(int'(cmd[15:0]));
                8'h03: begin
                    testId = int'(cmd[23:16]);
                    checkValue(int'(cmd[11:8]), cmd[7:0]);
                end
                8'h04: applyReset();
                default: begin
                    $display("Unknown command %h at entry %0d of the data file", cmd, i);
                    $display("Simulation failed");
                    $fatal(1);
                end
            endcase
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- verilog.f
rtl/cpuPkg.sv
rtl/counterReg.sv
rtl/registerFile.sv
rtl/addressRegFile.sv
rtl/instrRegister.sv
rtl/alu.sv
rtl/dataMemory.sv
rtl/controlUnit.sv
rtl/cpuTop.sv
dv/cpuTb.sv

//--- Makefile
TOP = cpuTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o cpuSim
	@out=$$(./obj_dir/cpuSim); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

//--- dv/programInput.mem
// kind in [31:24]: 01 load 0100AADD, 02 run 0200NNNN, 03 check 03TT0IEE, 04 reset, 0f end
// check index I: 0-3 R1-R4, 4 PC, 5 AR, 6 flags {Z,C,N,O}, 7 instrDone; TT is the test number
03010000 03010100 03010200 03010300 03010400 03010500 03010600 03010700
0100000F 010001C0  // LD R1,#0F
0100023C 010003C1  // LD R2,#3C
01000400 010005B2  // MOV R3,R1
01000601 01000703  // AND R4,R1,R2
01000801 01000912  // OR R3,R1,R2
01000A00 01000B20  // NOT R1,R1
01000C03 01000D03  // AND R4,R1,R4 gives zero
02000006 030200F0 0302013C 0302023F 0302030C 0302040C 03020602
02000001 03020300 03020608 0302040E
04000000
010000C8 010001C0  // LD R1,#C8
01000265 010003C1  // LD R2,#65
01000401 01000532  // ADD R3,R1,R2 carry out
01000670 010007C0  // LD R1,#70
01000800 01000933  // ADD R4,R1,R1 signed overflow
01000A00 01000BB2  // MOV R3,R1 keeps O
01000C10 01000D42  // SUB R3,R2,R1 with A < B
01000E01 01000F42  // SUB R3,R1,R2 with A >= B
01001030 01001163  // LSL R4,R4
01001210 01001352  // LSR R3,R2
01001401 01001510  // OR R1,R1,R2 keeps C
02000003 0303022D 03030604 03030406
02000002 030303E0 03030603 0303040A
02000001 03030270 03030601
02000001 030302F5 03030602
02000001 0303020B 03030604
02000001 030303C0 03030606
02000001 03030232 03030604
02000001 03030075 03030604 03030416
04000000
010000FF 010001C0  // LD R1,#FF
01000200 01000332  // ADD R3,R1,R1 sets C and N
01000400 01000570  // INC R1 wraps
01000600 01000781  // DEC R2 wraps
02000004 03040000 030401FF 030402FE 03040606 03040408
04000000
01000080 010001C0  // LD R1,#80
01000200 010003B4  // MOV AR,R1
010004A5 010005C1  // LD R2,#A5
01000600 010007D1  // ST R2 to M[AR]
01000800 010009C6  // LD R3 from M[AR]
01000A3C 01000BC3  // LD R4,#3C
02000006 03050580 03050080 030501A5 030502A5 0305033C 03050602 0305040C
04000000
01000003 010001C0  // LD R1,#03
01000201 010003C1  // LD R2,#01
01000410 01000590  // BRA 10
01001001 01001140  // SUB R1,R1,R2
01001210 010013A0  // BNE 10
01001477 010015C2  // LD R3,#77
02000003 03060410 03060003
02000002 03060002 03060410
02000004 03060000 0306060C 03060414
02000001 03060277 03060416
0F000000
